/* hdl/cache_access_pkg.sv */
package cache_access_pkg;

    // one access to the array
    // cmp=1 read or store, cmp=0 fill
    typedef struct packed {
        logic                      enable;
        logic                      cmp;
        logic                      write;
        // only a store looks at these
        cache_geom_pkg::byte_en_t  byte_en;
        // valid bit written by a fill
        logic                      valid_in;
        cache_geom_pkg::tag_t      tag;
        cache_geom_pkg::index_t    index;
        cache_geom_pkg::word_sel_t word_sel;
        // store word
        cache_geom_pkg::word_t     data;
        // fill block
        cache_geom_pkg::block_t    block;
    } cache_req_t;

    // lookup result, combinational on the request
    typedef struct packed {
        logic                   hit;
        logic                   dirty;
        logic                   valid;
        cache_geom_pkg::tag_t   tag;
        cache_geom_pkg::word_t  word;
        // whole stored block for write-back
        cache_geom_pkg::block_t wb_block;
    } cache_rsp_t;

    // write bundle for one word bank
    typedef struct packed {
        logic                     wen;
        cache_geom_pkg::byte_en_t byte_en;
        cache_geom_pkg::word_t    data;
    } steer_t;

endpackage

/* hdl/cache_block_gather.sv */
module cache_block_gather (
    input  cache_geom_pkg::word_t     words [cache_geom_pkg::block_words],
    input  cache_geom_pkg::word_sel_t word_sel,
    output cache_geom_pkg::word_t     word,
    output cache_geom_pkg::block_t    wb_block
);

    // pack banks into the write-back block
    // word 0 goes to the low bits
    always_comb begin
        for (int k = 0; k < cache_geom_pkg::block_words; k++) begin
            wb_block[k*cache_geom_pkg::data_width +: cache_geom_pkg::data_width] = words[k];
        end
    end

    ////////////////////
    // word select
    ////////////////////

    // plain mux on the word position
    always_comb begin
        case (word_sel)
            3'd0:    word = words[0];
            3'd1:    word = words[1];
            3'd2:    word = words[2];
            3'd3:    word = words[3];
            3'd4:    word = words[4];
            3'd5:    word = words[5];
            3'd6:    word = words[6];
            default: word = words[7];
        endcase
    end

endmodule

/* hdl/cache_geom_pkg.sv */
package cache_geom_pkg;

    ////////////////////
    // geometry
    ////////////////////

    // word select bits inside a block
    localparam int offset_width = 3;
    // words per block
    localparam int block_words = 1 << offset_width;

    // line address bits
    localparam int index_width = 4;
    // number of lines
    localparam int cache_depth = 1 << index_width;

    // tag takes what is left of a 30-bit word address
    localparam int tag_width = 30 - offset_width - index_width;

    // data word
    localparam int data_width = 32;
    localparam int bytes_per_word = data_width / 8;

    ////////////////////
    // width types
    ////////////////////

    // stored or requested tag
    typedef logic [tag_width-1:0] tag_t;

    // line address
    typedef logic [index_width-1:0] index_t;

    // word position in a block
    typedef logic [offset_width-1:0] word_sel_t;

    // one data word
    typedef logic [data_width-1:0] word_t;

    // byte write enables, bit b covers data bits 8b+7..8b
    typedef logic [bytes_per_word-1:0] byte_en_t;

    // full block, word 0 sits in the low bits
    typedef logic [block_words*data_width-1:0] block_t;

endpackage

/* hdl/cache_line_array.sv */
module cache_line_array (
    input  logic                         clk,
    input  logic                         reset,
    input  cache_access_pkg::cache_req_t req,
    output cache_access_pkg::cache_rsp_t rsp
);

    ////////////////////
    // internal nets
    ////////////////////

    logic                   hit;
    logic                   valid;
    logic                   dirty;
    cache_geom_pkg::tag_t   tag;
    cache_geom_pkg::word_t  word;
    cache_geom_pkg::block_t wb_block;

    // bank write bundles and bank read words
    cache_access_pkg::steer_t steer [cache_geom_pkg::block_words];
    cache_geom_pkg::word_t    words [cache_geom_pkg::block_words];

    // tag, valid and dirty bookkeeping
    cache_tag_store tag_store_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .hit   (hit),
        .valid (valid),
        .dirty (dirty),
        .tag   (tag)
    );

    // store and fill steering
    cache_word_steer word_steer_i (
        .req   (req),
        .hit   (hit),
        .steer (steer)
    );

    ////////////////////
    // data banks
    ////////////////////

    for (genvar k = 0; k < cache_geom_pkg::block_words; k++) begin : bank_gen
        cache_word_bank bank_i (
            .clk   (clk),
            .steer (steer[k]),
            .index (req.index),
            .word  (words[k])
        );
    end

    // block and word readout
    cache_block_gather block_gather_i (
        .words    (words),
        .word_sel (req.word_sel),
        .word     (word),
        .wb_block (wb_block)
    );

    assign rsp = '{hit: hit, dirty: dirty, valid: valid, tag: tag,
                   word: word, wb_block: wb_block};

endmodule

/* hdl/cache_tag_store.sv */
module cache_tag_store (
    input  logic                       clk,
    input  logic                       reset,
    input  cache_access_pkg::cache_req_t req,
    output logic                       hit,
    output logic                       valid,
    output logic                       dirty,
    output cache_geom_pkg::tag_t       tag
);

    ////////////////////
    // state
    ////////////////////

    // one tag per line
    cache_geom_pkg::tag_t tag_mem [cache_geom_pkg::cache_depth];
    // one bit per line
    logic [cache_geom_pkg::cache_depth-1:0] valid_mem;
    logic [cache_geom_pkg::cache_depth-1:0] dirty_mem;

    logic match;
    logic fill;
    logic store_hit;

    ////////////////////
    // lookup
    ////////////////////

    // stored tag is always visible
    assign tag   = tag_mem[req.index];
    assign match = (tag_mem[req.index] == req.tag);

    assign hit   = req.enable & match;
    assign valid = req.enable & valid_mem[req.index];
    // dirty only shows on a compare miss
    // the controller uses it to decide on write-back
    assign dirty = req.enable & req.cmp & ~match & dirty_mem[req.index];

    // fill ignores the tag compare
    assign fill      = req.enable & req.write & ~req.cmp;
    // store marks the line only when it really lands
    assign store_hit = req.enable & req.write & req.cmp & match;

    ////////////////////
    // update
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cache_geom_pkg::cache_depth; i++) begin
                tag_mem[i] <= '0;
            end
            valid_mem <= '0;
            dirty_mem <= '0;
        end else begin
            if (fill) begin
                // new block, clean copy of memory
                tag_mem[req.index]   <= req.tag;
                valid_mem[req.index] <= req.valid_in;
                dirty_mem[req.index] <= 1'b0;
            end else if (store_hit) begin
                dirty_mem[req.index] <= 1'b1;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // a live access names a known kind and line
    ctrl_known: assert property (@(posedge clk) disable iff (reset)
        req.enable |-> !$isunknown({req.write, req.cmp, req.index}));

    // reset leaves no line valid
    valid_cleared: assert property (@(posedge clk) reset |=> (valid_mem == '0));

endmodule

/* hdl/cache_word_bank.sv */
module cache_word_bank (
    input  logic                     clk,
    input  cache_access_pkg::steer_t steer,
    input  cache_geom_pkg::index_t   index,
    output cache_geom_pkg::word_t    word
);

    ////////////////////
    // storage
    ////////////////////

    // one word per line, this column only
    cache_geom_pkg::word_t mem [cache_geom_pkg::cache_depth];

    // read is combinational at the current index
    assign word = mem[index];

    ////////////////////
    // byte write
    ////////////////////

    always_ff @(posedge clk) begin
        if (steer.wen) begin
            for (int b = 0; b < cache_geom_pkg::bytes_per_word; b++) begin
                // untouched bytes keep their old value
                if (steer.byte_en[b]) begin
                    mem[index][8*b +: 8] <= steer.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hdl/cache_word_steer.sv */
module cache_word_steer (
    input  cache_access_pkg::cache_req_t req,
    input  logic                         hit,
    output cache_access_pkg::steer_t     steer [cache_geom_pkg::block_words]
);

    logic store;
    logic fill;
    // per-bank write enables
    logic [cache_geom_pkg::block_words-1:0] wen_vec;

    // decode the access kind
    assign store = req.enable & req.write & req.cmp;
    assign fill  = req.enable & req.write & ~req.cmp;

    ////////////////////
    // per-bank bundles
    ////////////////////

    always_comb begin
        for (int k = 0; k < cache_geom_pkg::block_words; k++) begin
            // store hits one bank, fill hits all of them
            wen_vec[k] = (store & hit & (req.word_sel == cache_geom_pkg::word_sel_t'(k))) | fill;

            steer[k].wen = wen_vec[k];

            // store keeps its own byte mask
            // fill always writes whole words
            if (req.cmp) begin
                steer[k].byte_en = req.byte_en;
                steer[k].data    = req.data;
            end else begin
                steer[k].byte_en = '1;
                steer[k].data    = req.block[k*cache_geom_pkg::data_width +:
                                             cache_geom_pkg::data_width];
            end
        end
    end

endmodule

/* tb.f */
hdl/cache_geom_pkg.sv
hdl/cache_access_pkg.sv
hdl/cache_tag_store.sv
hdl/cache_word_steer.sv
hdl/cache_word_bank.sv
hdl/cache_block_gather.sv
hdl/cache_line_array.sv
verif/cache_line_array_tb.sv

/* verif/cache_line_array_tb.sv */
module cache_line_array_tb;

    ////////////////////
    // dut and stimulus
    ////////////////////

    // reads, stores and fills over all directed tests plus the random run
    localparam int n_reqs = 16 * 2 + 16 * 9 + 16 * 3 * 3 + 400;
    localparam int limit = (n_reqs + 100) * 20;

    logic clk;
    logic reset;
    cache_access_pkg::cache_req_t req;
    cache_access_pkg::cache_rsp_t rsp;

    cache_line_array dut_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp)
    );

    // model of the array
    cache_geom_pkg::tag_t tag_m [cache_geom_pkg::cache_depth];
    logic valid_m [cache_geom_pkg::cache_depth];
    logic dirty_m [cache_geom_pkg::cache_depth];
    logic filled_m [cache_geom_pkg::cache_depth];
    cache_geom_pkg::word_t data_m [cache_geom_pkg::cache_depth][cache_geom_pkg::block_words];

    string test_name;
    logic checking;
    int errors;
    int checks;
    int tests;
    int test_err_start;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////

    // expected lookup result from the model state before the edge
    function automatic cache_access_pkg::cache_rsp_t expect_rsp(
        input cache_access_pkg::cache_req_t r);
        cache_access_pkg::cache_rsp_t e;
        logic match;
        match = (tag_m[r.index] == r.tag);
        e.hit = r.enable & match;
        e.valid = r.enable & valid_m[r.index];
        // victim dirty only on a compare miss
        e.dirty = r.enable & r.cmp & ~match & dirty_m[r.index];
        e.tag = tag_m[r.index];
        e.word = data_m[r.index][r.word_sel];
        for (int k = 0; k < cache_geom_pkg::block_words; k++) begin
            e.wb_block[k*32 +: 32] = data_m[r.index][k];
        end
        return e;
    endfunction

    // commit a request to the model by the write rules
    task automatic update_model(input cache_access_pkg::cache_req_t r);
        if (r.enable && r.write && !r.cmp) begin
            tag_m[r.index] = r.tag;
            valid_m[r.index] = r.valid_in;
            dirty_m[r.index] = 1'b0;
            filled_m[r.index] = 1'b1;
            for (int k = 0; k < cache_geom_pkg::block_words; k++) begin
                data_m[r.index][k] = r.block[k*32 +: 32];
            end
        end else if (r.enable && r.write && tag_m[r.index] == r.tag) begin
            // store hit, only enabled bytes change
            for (int b = 0; b < cache_geom_pkg::bytes_per_word; b++) begin
                if (r.byte_en[b]) begin
                    data_m[r.index][r.word_sel][8*b +: 8] = r.data[8*b +: 8];
                end
            end
            dirty_m[r.index] = 1'b1;
        end
    endtask

    ////////////////////
    // checker
    ////////////////////

    task automatic check_value(input string field, input logic [255:0] expv,
                               input logic [255:0] actv);
        checks++;
        assert (expv === actv) else begin
            $display("CHECK FAILED %s %s expected %0h actual %0h",
                     test_name, field, expv, actv);
            errors++;
        end
    endtask

    // lookup fields are stable by the falling edge
    always @(negedge clk) begin
        cache_access_pkg::cache_rsp_t exp_rsp;
        if (checking) begin
            exp_rsp = expect_rsp(req);
            check_value("hit", exp_rsp.hit, rsp.hit);
            check_value("dirty", exp_rsp.dirty, rsp.dirty);
            check_value("valid", exp_rsp.valid, rsp.valid);
            check_value("tag", exp_rsp.tag, rsp.tag);
            // bank data is undefined until a fill
            if (filled_m[req.index]) begin
                check_value("word", exp_rsp.word, rsp.word);
                check_value("wb_block", exp_rsp.wb_block, rsp.wb_block);
            end
        end
    end

    // run out of time means something stalled
    initial begin
        #(limit);
        $display("watchdog expired after %0d time units, run did not complete", limit);
        $display("Finished with errors");
        $finish;
    end

    ////////////////////
    // request helpers
    ////////////////////

    function automatic cache_access_pkg::cache_req_t read_req(
        input cache_geom_pkg::tag_t tag, input int idx, input int ws);
        cache_access_pkg::cache_req_t r;
        r = '0;
        r.enable = 1'b1;
        r.cmp = 1'b1;
        r.tag = tag;
        r.index = idx;
        r.word_sel = ws;
        return r;
    endfunction

    function automatic cache_access_pkg::cache_req_t store_req(
        input cache_geom_pkg::tag_t tag, input int idx, input int ws);
        cache_access_pkg::cache_req_t r;
        r = read_req(tag, idx, ws);
        r.write = 1'b1;
        r.byte_en = $urandom;
        r.data = $urandom;
        return r;
    endfunction

    function automatic cache_access_pkg::cache_req_t fill_req(
        input cache_geom_pkg::tag_t tag, input int idx, input logic valid_in);
        cache_access_pkg::cache_req_t r;
        r = read_req(tag, idx, $urandom % 8);
        r.cmp = 1'b0;
        r.write = 1'b1;
        r.valid_in = valid_in;
        for (int k = 0; k < cache_geom_pkg::block_words; k++) begin
            r.block[k*32 +: 32] = $urandom;
        end
        return r;
    endfunction

    // hold one request for a cycle, model follows at the edge
    task automatic do_req(input cache_access_pkg::cache_req_t r);
        req = r;
        checking = 1'b1;
        @(posedge clk);
        update_model(r);
        #2;
        checking = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done, %0d errors", test_name, errors - test_err_start);
    endtask

    ////////////////////
    // tests
    ////////////////////

    initial begin
        cache_access_pkg::cache_req_t r;
        cache_geom_pkg::tag_t tag;
        cache_geom_pkg::tag_t pool [4];
        int idx;
        void'($urandom(32'hc32b));
        reset = 1'b1;
        req = '0;
        checking = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_name = "reset";
        // tags reset to zero, data stays unknown
        for (int i = 0; i < cache_geom_pkg::cache_depth; i++) begin
            tag_m[i] = '0;
            valid_m[i] = 1'b0;
            dirty_m[i] = 1'b0;
            filled_m[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        start_test("after_reset");
        for (int i = 0; i < 16; i++) begin
            do_req(read_req('0, i, $urandom % 8));
            tag = $urandom;
            do_req(read_req((tag == '0) ? 23'd1 : tag, i, $urandom % 8));
        end
        end_test();

        start_test("fill_read");
        for (int i = 0; i < 16; i++) begin
            do_req(fill_req($urandom, i, $urandom % 2));
            for (int w = 0; w < 8; w++) begin
                do_req(read_req(tag_m[i], i, w));
            end
        end
        end_test();

        start_test("store_hit");
        for (int i = 0; i < 16; i++) begin
            r = store_req(tag_m[i], i, $urandom % 8);
            do_req(r);
            do_req(read_req(tag_m[i], i, r.word_sel));
            // wrong tag exposes the dirty victim
            do_req(read_req(tag_m[i] ^ 23'd1, i, r.word_sel));
        end
        end_test();

        start_test("store_miss");
        for (int i = 0; i < 16; i++) begin
            r = store_req(tag_m[i] ^ 23'd2, i, $urandom % 8);
            do_req(r);
            do_req(read_req(tag_m[i], i, r.word_sel));
            do_req(read_req(tag_m[i] ^ 23'd1, i, r.word_sel));
        end
        end_test();

        start_test("fill_dirty");
        for (int i = 0; i < 16; i++) begin
            // old block shows on wb_block during the fill
            do_req(fill_req(tag_m[i] ^ 23'h40, i, 1'b1));
            do_req(read_req(tag_m[i] ^ 23'd1, i, $urandom % 8));
            do_req(read_req(tag_m[i], i, $urandom % 8));
        end
        end_test();

        start_test("random");
        for (int p = 0; p < 4; p++) begin
            pool[p] = $urandom;
        end
        for (int n = 0; n < 400; n++) begin
            idx = $urandom % 16;
            tag = pool[$urandom % 4];
            case ($urandom % 3)
                0: r = read_req(tag, idx, $urandom % 8);
                1: r = store_req(tag, idx, $urandom % 8);
                default: r = fill_req(tag, idx, $urandom % 2);
            endcase
            // some idle cycles in between
            r.enable = ($urandom % 8 != 0);
            do_req(r);
        end
        end_test();

        req = '0;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
